// File: lc3_core.f
common/lc3_pkg.sv
decode/regfile.sv
decode/decode.sv
verilog/fetch.sv
verilog/controller.sv
verilog/execute.sv
verilog/mem_port.sv
verilog/lc3_core.sv
dv/lc3_core_checker.sv
dv/lc3_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module lc3_core_tb -f lc3_core.f -o lc3_core_sim

./obj_dir/lc3_core_sim | tee sim.log

if grep -q "Result: FAILED" sim.log
then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// File: dv/lc3_core_tb.sv
// LC-3 core random program testbench
`timescale 1ns/1ps

module lc3_core_tb;

  localparam int max_wait  = 200; // Cycles for any handshake wait
  localparam int max_steps = 400; // Instructions per run
  localparam int halt_wait = 50;
  localparam logic [2:0] t_fetch = 3'd0;
  localparam logic [2:0] t_load  = 3'd1;
  localparam logic [2:0] t_store = 3'd2;
  localparam logic [2:0] t_reset = 3'd3;
  localparam logic [2:0] t_halt  = 3'd4;

  logic              clock;
  logic              reset;
  logic              ack;
  lc3_pkg::word_t    rdata;
  logic              req;
  lc3_pkg::mem_bus_t bus;

  lc3_pkg::word_t image [65536]; // Program and data, loaded per run
  lc3_pkg::word_t mem   [65536]; // DUT side memory
  lc3_pkg::word_t mmem  [65536]; // Model memory
  lc3_pkg::word_t mreg  [8];
  logic [2:0]     mcc;           // Model N, Z, P
  lc3_pkg::word_t mpc;
  logic [31:0]    rng;
  logic           stop;          // A wait timed out
  int             checks [8];
  int             errors [8];
  int             total_checks;
  int             total_errors;

  lc3_core dut (
    .clock (clock),
    .reset (reset),
    .ack   (ack),
    .rdata (rdata),
    .req   (req),
    .bus   (bus)
  );

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int pick(input int n);
    rng = xorshift(rng);
    return int'(rng % 32'(n));
  endfunction

  // Sign-extend the low bits of v
  function automatic lc3_pkg::word_t sext(input lc3_pkg::word_t v, input int bits);
    lc3_pkg::word_t m;
    m = 16'hffff << bits;
    if ((v & (16'd1 << (bits - 1))) != 16'd0)
      return v | m;
    return v & ~m;
  endfunction

  function automatic string test_name(input logic [2:0] t);
    case (t)
      t_fetch: return "fetch_order";
      t_load:  return "load_address";
      t_store: return "store_data";
      t_reset: return "reset_idle";
      default: return "trap_halt";
    endcase
  endfunction

  task automatic check_word(input logic [2:0] t, input string name,
                            input lc3_pkg::word_t exp, input lc3_pkg::word_t got);
    checks[t]++;
    if (got !== exp)
    begin
      errors[t]++;
      $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic give_up(input logic [2:0] t, input string what);
    errors[t]++;
    stop = 1'b1;
    $display("Timeout at t=%0t while waiting for %s", $time, what);
  endtask

  // One four-phase transaction, checked against the model's prediction
  task automatic serve(input logic [2:0] t, input lc3_pkg::word_t addr, input logic wr,
                       input lc3_pkg::word_t data);
    int n;
    int delay;
    n = 0;
    while (!req && n < max_wait)
    begin
      @(negedge clock);
      n++;
    end
    if (!req)
    begin
      give_up(t, "a memory request");
      return;
    end
    check_word(t, "bus.addr", addr, bus.addr);
    check_word(t, "bus.write", {15'd0, wr}, {15'd0, bus.write});
    if (wr)
      check_word(t, "bus.wdata", data, bus.wdata);
    delay = pick(4); // Slow memory, 0 to 3 cycles
    repeat (delay) @(negedge clock);
    if (bus.write)
      mem[bus.addr] = bus.wdata;
    else
      rdata = mem[bus.addr];
    ack = 1'b1;
    n = 0;
    while (req && n < max_wait)
    begin
      @(negedge clock);
      n++;
    end
    if (req)
      give_up(t, "req to fall");
    delay = pick(4); // Late ack release, next request must wait
    repeat (delay) @(negedge clock);
    ack = 1'b0;
  endtask

  task automatic check_halt();
    int n;
    checks[t_halt]++;
    for (n = 0; n < halt_wait; n++)
    begin
      @(negedge clock);
      if (req)
      begin
        errors[t_halt]++;
        $display("Core did not halt, request seen at t=%0t after TRAP", $time);
        break;
      end
    end
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset = 1'b1;
    ack   = 1'b0;
    rdata = '0;
    repeat (5)
    begin
      @(negedge clock);
      check_word(t_reset, "req", 16'd0, {15'd0, req});
      check_word(t_reset, "bus.write", 16'd0, {15'd0, bus.write});
    end
    reset = 1'b0;
  endtask

  task automatic set_reg(input lc3_pkg::reg_addr_t r, input lc3_pkg::word_t v);
    mreg[r] = v;
    if (v[15])
      mcc = 3'b100;
    else if (v == 16'd0)
      mcc = 3'b010;
    else
      mcc = 3'b001;
  endtask

  task automatic put(inout lc3_pkg::word_t p, input lc3_pkg::word_t w);
    image[p] = w;
    p = p + 16'd1;
  endtask

  task automatic gen_program();
    lc3_pkg::word_t p;
    lc3_pkg::word_t off;
    logic [3:0]     op;
    logic [2:0]     dr;
    logic [2:0]     sa;
    logic [2:0]     sb;
    int             skip;
    for (int a = 0; a < 65536; a++)
      image[16'(a)] = 16'(a) ^ 16'h5a3c; // Background fill
    for (int a = 16'h2fc0; a < 16'h3000; a++)
      image[16'(a)] = 16'(pick(65536)); // Data window
    p = lc3_pkg::reset_pc;
    for (int r = 0; r < 8; r++)
      put(p, {4'h5, 3'(r), 3'(r), 1'b1, 5'd0}); // Clear R0..R7, sets cc
    off = 16'h2fe0 - (p + 16'd1);
    put(p, {4'he, 3'd6, off[8:0]}); // R6 points mid window
    for (int r = 0; r < 5; r++)
      put(p, {4'h1, 3'(r), 3'(r), 1'b1, 5'(pick(32))});
    while (p < 16'h3078)
    begin
      dr = 3'(pick(5)); // R5..R7 reserved
      sa = 3'(pick(8));
      sb = 3'(pick(8));
      case (pick(10))
        0, 1:
        begin
          op = (pick(2) == 0) ? 4'h1 : 4'h5;
          if (pick(2) == 0)
            put(p, {op, dr, sa, 3'b000, sb});
          else
            put(p, {op, dr, sa, 1'b1, 5'(pick(32))});
        end
        2: put(p, {4'h9, dr, sa, 6'h3f});
        3:
        begin
          skip = pick(3);
          put(p, {4'h0, 3'(pick(8)), 9'(skip)}); // Forward BR over plain words
          repeat (skip) put(p, {4'h9, 3'(pick(5)), 3'(pick(8)), 6'h3f});
        end
        4:
        begin
          off = 16'h2fc0 + 16'(pick(64)) - (p + 16'd1);
          put(p, {4'h2, dr, off[8:0]});
        end
        5:
        begin
          off = 16'h2fc0 + 16'(pick(64)) - (p + 16'd1);
          put(p, {4'h3, sa, off[8:0]});
        end
        6: put(p, {4'h6, dr, 3'd6, 6'(pick(64))});
        7: put(p, {4'h7, sa, 3'd6, 6'(pick(64))});
        8: put(p, {4'he, dr, 9'(pick(512))});
        default:
        begin
          case (pick(3))
            0:
            begin
              put(p, {4'h4, 1'b1, 11'd1});      // JSR to the RET
              put(p, {4'h0, 3'b111, 9'd1});     // Return lands here, skip RET
              put(p, {4'hc, 3'd0, 3'd7, 6'd0}); // RET
            end
            1:
            begin
              put(p, {4'he, 3'd5, 9'd1});
              put(p, {4'h4, 3'b000, 3'd5, 6'd0}); // JSRR R5
            end
            default:
            begin
              put(p, {4'he, 3'd5, 9'd2});
              put(p, {4'hc, 3'd0, 3'd5, 6'd0}); // JMP R5 over the TRAP
              put(p, 16'hf025);
            end
          endcase
        end
      endcase
    end
    repeat (4) put(p, 16'hf025); // Program end
  endtask

  task automatic run_program();
    lc3_pkg::word_t inst;
    lc3_pkg::word_t npc;
    lc3_pkg::word_t ea;
    lc3_pkg::word_t b;
    logic           halted;
    int             step;
    for (int a = 0; a < 65536; a++)
    begin
      mem[16'(a)]  = image[16'(a)];
      mmem[16'(a)] = image[16'(a)];
    end
    for (int r = 0; r < 8; r++)
      mreg[3'(r)] = '0;
    mcc    = 3'b010;
    mpc    = lc3_pkg::reset_pc;
    halted = 1'b0;
    stop   = 1'b0;
    apply_reset();
    for (step = 0; step < max_steps && !stop && !halted; step++)
    begin
      serve((step == 0) ? t_reset : t_fetch, mpc, 1'b0, '0);
      inst = mmem[mpc];
      npc  = mpc + 16'd1;
      b    = mreg[inst[8:6]]; // Base or SR1
      case (inst[15:12])
        lc3_pkg::op_add:
          set_reg(inst[11:9], b + (inst[5] ? sext(inst, 5) : mreg[inst[2:0]]));
        lc3_pkg::op_and:
          set_reg(inst[11:9], b & (inst[5] ? sext(inst, 5) : mreg[inst[2:0]]));
        lc3_pkg::op_not: set_reg(inst[11:9], ~b);
        lc3_pkg::op_br:
          if ((mcc & inst[11:9]) != 3'b000)
            npc = npc + sext(inst, 9);
        lc3_pkg::op_jmp: npc = b;
        lc3_pkg::op_jsr:
        begin
          mreg[7] = npc; // Link leaves cc alone
          npc = inst[11] ? npc + sext(inst, 11) : b;
        end
        lc3_pkg::op_ld, lc3_pkg::op_ldr:
        begin
          ea = (inst[15:12] == lc3_pkg::op_ld) ? npc + sext(inst, 9) : b + sext(inst, 6);
          serve(t_load, ea, 1'b0, '0);
          set_reg(inst[11:9], mmem[ea]);
        end
        lc3_pkg::op_lea: set_reg(inst[11:9], npc + sext(inst, 9));
        lc3_pkg::op_st, lc3_pkg::op_str:
        begin
          ea = (inst[15:12] == lc3_pkg::op_st) ? npc + sext(inst, 9) : b + sext(inst, 6);
          serve(t_store, ea, 1'b1, mreg[inst[11:9]]);
          mmem[ea] = mreg[inst[11:9]];
        end
        lc3_pkg::op_trap:
        begin
          check_halt();
          halted = 1'b1;
        end
        default:
        begin
          errors[t_fetch]++;
          stop = 1'b1;
          $display("Model fetched an unexpected opcode %h at %h", inst[15:12], mpc);
        end
      endcase
      mpc = npc;
    end
    if (!halted && !stop)
    begin
      errors[t_halt]++;
      $display("Program did not reach its TRAP within %0d instructions", max_steps);
    end
  endtask

  initial
  begin
    reset = 1'b1;
    ack   = 1'b0;
    rdata = '0;
    rng   = 32'h09cb_a694;
    stop  = 1'b0;
    for (int t = 0; t < 8; t++)
    begin
      checks[3'(t)] = 0;
      errors[3'(t)] = 0;
    end
    gen_program();
    run_program();
    run_program(); // Same program, other ack delays
    total_checks = 0;
    total_errors = 0;
    for (int t = 0; t < 5; t++)
    begin
      $display("%-12s checks %0d errors %0d", test_name(3'(t)), checks[3'(t)],
               errors[3'(t)]);
      total_checks += checks[3'(t)];
      total_errors += errors[3'(t)];
    end
    $display("Total checks %0d, errors %0d", total_checks, total_errors);
    if (total_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: dv/lc3_core_checker.sv
// Memory handshake assertions
`timescale 1ns/1ps

module lc3_core_checker (
  input logic              clock,
  input logic              reset,
  input logic              req,
  input logic              ack,
  input lc3_pkg::mem_bus_t bus
);

  // Request held with a stable bus until the memory answers
  property req_held;
    @(posedge clock) disable iff (reset)
      req && !ack |=> req && $stable(bus);
  endproperty

  property write_with_req;
    @(posedge clock) disable iff (reset)
      bus.write |-> req;
  endproperty

  // Old ack still high, no new request yet
  property no_req_under_ack;
    @(posedge clock) disable iff (reset)
      ack && !req |=> !req;
  endproperty

  assert property (req_held) else $error("req dropped or bus changed before ack");
  assert property (write_with_req) else $error("write flag high without req");
  assert property (no_req_under_ack) else $error("req raised while ack still high");

endmodule

bind lc3_core lc3_core_checker u_checker (
  .clock (clock),
  .reset (reset),
  .req   (req),
  .ack   (ack),
  .bus   (bus)
);

// File: verilog/lc3_core.sv
// LC-3 multicycle core top
`timescale 1ns/1ps

module lc3_core (
  input  logic              clock,
  input  logic              reset,
  input  logic              ack,   // Memory handshake acknowledge
  input  lc3_pkg::word_t    rdata, // Valid while ack is high
  output logic              req,
  output lc3_pkg::mem_bus_t bus
);

  lc3_pkg::state_t     state;
  lc3_pkg::seq_ctrl_t  seq;
  lc3_pkg::exec_ctrl_t exec;
  lc3_pkg::word_t      pc;
  lc3_pkg::word_t      next_pc;
  lc3_pkg::word_t      ir;
  lc3_pkg::word_t      src1;
  lc3_pkg::word_t      src2;
  lc3_pkg::word_t      target;
  lc3_pkg::word_t      result;
  lc3_pkg::word_t      mem_data;
  logic                br_taken;
  logic                done;

  fetch u_fetch (
    .clock    (clock),
    .reset    (reset),
    .state    (state),
    .br_taken (br_taken),
    .target   (target),
    .pc       (pc),
    .next_pc  (next_pc)
  );

  controller u_controller (
    .clock (clock),
    .reset (reset),
    .seq   (seq),
    .done  (done),
    .state (state)
  );

  decode u_decode (
    .clock      (clock),
    .state      (state),
    .rdata_word (mem_data), // Fetched word, registered in mem_port
    .result     (result),
    .seq        (seq),
    .exec       (exec),
    .ir         (ir),
    .src1       (src1),
    .src2       (src2),
    .br_taken   (br_taken)
  );

  execute u_execute (
    .exec     (exec),
    .ir       (ir),
    .src1     (src1),
    .src2     (src2),
    .next_pc  (next_pc),
    .mem_data (mem_data),
    .target   (target),
    .result   (result)
  );

  mem_port u_mem_port (
    .clock      (clock),
    .reset      (reset),
    .state      (state),
    .pc         (pc),
    .target     (target),
    .store_data (src2), // ST/STR source register
    .ack        (ack),
    .rdata      (rdata),
    .req        (req),
    .bus        (bus),
    .done       (done),
    .mem_data   (mem_data)
  );

endmodule

// File: verilog/mem_port.sv
// Four-phase memory request port
`timescale 1ns/1ps

module mem_port (
  input  logic              clock,
  input  logic              reset,
  input  lc3_pkg::state_t   state,
  input  lc3_pkg::word_t    pc,
  input  lc3_pkg::word_t    target,
  input  lc3_pkg::word_t    store_data,
  input  logic              ack,
  input  lc3_pkg::word_t    rdata,
  output logic              req,
  output lc3_pkg::mem_bus_t bus,
  output logic              done,     // One cycle, access complete
  output lc3_pkg::word_t    mem_data  // Last read word
);

  logic           access;  // State needs a memory transaction
  logic           launch;
  logic           write_q;
  lc3_pkg::word_t addr_q;
  lc3_pkg::word_t wdata_q;

  assign access = state inside {lc3_pkg::fetch, lc3_pkg::read_mem, lc3_pkg::write_mem};
  // No new request until the previous ack is gone
  assign launch = access && !req && !done && !ack;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      req     <= 1'b0;
      write_q <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (req && ack)
      begin
        req     <= 1'b0; // Drop on the cycle after ack
        write_q <= 1'b0;
        done    <= 1'b1;
      end
      else if (launch)
      begin
        req     <= 1'b1;
        write_q <= (state == lc3_pkg::write_mem);
      end
    end
  end

  // Bus held from launch until ack
  always_ff @(posedge clock)
  begin
    if (launch)
    begin
      addr_q  <= (state == lc3_pkg::fetch) ? pc : target;
      wdata_q <= store_data;
    end
  end

  always_ff @(posedge clock)
  begin
    if (req && ack)
      mem_data <= rdata; // Valid while ack high
  end

  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.write = write_q;

endmodule

// File: verilog/execute.sv
// ALU, address adder and writeback select
`timescale 1ns/1ps

module execute (
  input  lc3_pkg::exec_ctrl_t exec,
  input  lc3_pkg::word_t      ir,
  input  lc3_pkg::word_t      src1,
  input  lc3_pkg::word_t      src2,
  input  lc3_pkg::word_t      next_pc,
  input  lc3_pkg::word_t      mem_data,
  output lc3_pkg::word_t      target,   // Base plus offset
  output lc3_pkg::word_t      result
);

  lc3_pkg::word_t imm5;
  lc3_pkg::word_t offset6;
  lc3_pkg::word_t offset9;
  lc3_pkg::word_t offset11;
  lc3_pkg::word_t alu_in2;
  lc3_pkg::word_t alu_out;
  lc3_pkg::word_t offset;
  lc3_pkg::word_t base;

  // Sign extension of the instruction fields
  assign imm5     = {{11{ir[4]}}, ir[4:0]};
  assign offset6  = {{10{ir[5]}}, ir[5:0]};
  assign offset9  = {{7{ir[8]}}, ir[8:0]};
  assign offset11 = {{5{ir[10]}}, ir[10:0]};

  assign alu_in2 = exec.use_imm ? imm5 : src2;

  always_comb
  begin
    case (exec.alu_op)
      lc3_pkg::alu_and: alu_out = src1 & alu_in2;
      lc3_pkg::alu_not: alu_out = ~src1;
      default:          alu_out = src1 + alu_in2;
    endcase
  end

  always_comb
  begin
    case (exec.off_sel)
      lc3_pkg::off_11: offset = offset11;
      lc3_pkg::off_9:  offset = offset9;
      lc3_pkg::off_6:  offset = offset6;
      default:         offset = '0; // JMP, JSRR
    endcase
  end

  assign base   = (exec.base_sel == lc3_pkg::base_src1) ? src1 : next_pc;
  assign target = base + offset;

  always_comb
  begin
    case (exec.wb_sel)
      lc3_pkg::wb_mem:  result = mem_data;
      lc3_pkg::wb_addr: result = target;
      lc3_pkg::wb_npc:  result = next_pc; // Return address
      default:          result = alu_out;
    endcase
  end

endmodule

// File: verilog/controller.sv
// Instruction phase FSM
`timescale 1ns/1ps

module controller (
  input  logic               clock,
  input  logic               reset,
  input  lc3_pkg::seq_ctrl_t seq,
  input  logic               done,  // Memory access finished
  output lc3_pkg::state_t    state
);

  lc3_pkg::state_t next_state;

  always_comb
  begin
    next_state = state; // Hold by default, covers memory waits
    case (state)
      lc3_pkg::update_pc: next_state = lc3_pkg::fetch;
      lc3_pkg::fetch:
        if (done)
          next_state = lc3_pkg::decode;
      lc3_pkg::decode:
        case (seq.inst_class)
          lc3_pkg::alu:     next_state = lc3_pkg::execute;
          lc3_pkg::control: next_state = lc3_pkg::branch;
          lc3_pkg::load:    next_state = lc3_pkg::address;
          lc3_pkg::store:   next_state = lc3_pkg::address;
          default:          next_state = lc3_pkg::halt; // TRAP, RTI, LDI, STI, reserved
        endcase
      lc3_pkg::execute:   next_state = lc3_pkg::write_reg;
      lc3_pkg::write_reg: next_state = lc3_pkg::update_pc;
      lc3_pkg::branch:
        if (seq.store_pc)
          next_state = lc3_pkg::write_reg; // Link into R7
        else
          next_state = lc3_pkg::update_pc;
      lc3_pkg::address:
        if (seq.addr_only)
          next_state = lc3_pkg::write_reg; // LEA
        else if (seq.inst_class == lc3_pkg::load)
          next_state = lc3_pkg::read_mem;
        else
          next_state = lc3_pkg::write_mem;
      lc3_pkg::read_mem:
        if (done)
          next_state = lc3_pkg::write_reg;
      lc3_pkg::write_mem:
        if (done)
          next_state = lc3_pkg::update_pc;
      lc3_pkg::halt:      next_state = lc3_pkg::halt; // Only reset leaves
      default:            next_state = lc3_pkg::halt;
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      state <= lc3_pkg::update_pc;
    else
      state <= next_state;
  end

endmodule

// File: verilog/fetch.sv
// Program counter
`timescale 1ns/1ps

module fetch (
  input  logic            clock,
  input  logic            reset,
  input  lc3_pkg::state_t state,
  input  logic            br_taken,
  input  lc3_pkg::word_t  target,  // Branch or jump destination
  output lc3_pkg::word_t  pc,
  output lc3_pkg::word_t  next_pc  // Incremented PC, JSR link and branch base
);

  logic           started; // First update_pc after reset keeps x3000
  lc3_pkg::word_t pc_mux;

  assign next_pc = pc + 1'b1;
  assign pc_mux  = br_taken ? target : next_pc;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      pc      <= lc3_pkg::reset_pc;
      started <= 1'b0;
    end
    else if (state == lc3_pkg::update_pc)
    begin
      started <= 1'b1;
      if (started)
        pc <= pc_mux; // Advance past the finished instruction
    end
  end

endmodule

// File: decode/decode.sv
// Instruction decode and register file control
`timescale 1ns/1ps

module decode (
  input  logic                clock,
  input  lc3_pkg::state_t     state,
  input  lc3_pkg::word_t      rdata_word, // Fetched instruction
  input  lc3_pkg::word_t      result,     // Writeback value
  output lc3_pkg::seq_ctrl_t  seq,
  output lc3_pkg::exec_ctrl_t exec,
  output lc3_pkg::word_t      ir,
  output lc3_pkg::word_t      src1,
  output lc3_pkg::word_t      src2,
  output logic                br_taken
);

  lc3_pkg::word_t     inst;    // Word being decoded this cycle
  lc3_pkg::opcode_t   opcode;
  lc3_pkg::reg_addr_t dr;
  lc3_pkg::reg_addr_t sr1;
  lc3_pkg::reg_addr_t sr2;
  logic [2:0]         cc;      // N, Z, P
  logic               reg_write;

  // IR loads at the end of decode, so decode looks at the fetched word directly
  assign inst   = (state == lc3_pkg::decode) ? rdata_word : ir;
  assign opcode = lc3_pkg::opcode_t'(inst[15:12]);

  always_ff @(posedge clock)
  begin
    if (state == lc3_pkg::decode)
      ir <= rdata_word;
  end

  assign reg_write = (state == lc3_pkg::write_reg);

  // Condition codes follow every register write except the JSR link
  always_ff @(posedge clock)
  begin
    if (reg_write && opcode != lc3_pkg::op_jsr)
    begin
      if (result[15])
        cc <= 3'b100;
      else if (result == '0)
        cc <= 3'b010;
      else
        cc <= 3'b001;
    end
  end

  // Register numbers
  assign dr  = (opcode == lc3_pkg::op_jsr) ? 3'd7 : inst[11:9];
  assign sr1 = inst[8:6];
  assign sr2 = (opcode == lc3_pkg::op_st || opcode == lc3_pkg::op_str) ? inst[11:9]
             : inst[2:0];

  regfile u_regfile (
    .clock         (clock),
    .write         (reg_write),
    .write_reg_num (dr),
    .write_data    (result),
    .read_num1     (sr1),
    .read_num2     (sr2),
    .read_data1    (src1),
    .read_data2    (src2)
  );

  always_comb
  begin
    seq.inst_class = lc3_pkg::illegal;
    seq.store_pc   = 1'b0;
    seq.addr_only  = 1'b0;
    exec.alu_op    = lc3_pkg::alu_add;
    exec.off_sel   = lc3_pkg::off_9;
    exec.base_sel  = lc3_pkg::base_npc;
    exec.use_imm   = 1'b0;
    exec.wb_sel    = lc3_pkg::wb_alu;
    br_taken       = 1'b0;
    case (opcode)
      lc3_pkg::op_add, lc3_pkg::op_and, lc3_pkg::op_not:
      begin
        seq.inst_class = lc3_pkg::alu;
        exec.use_imm   = inst[5]; // Immediate mode bit
        if (opcode == lc3_pkg::op_and)
          exec.alu_op = lc3_pkg::alu_and;
        else if (opcode == lc3_pkg::op_not)
          exec.alu_op = lc3_pkg::alu_not;
      end
      lc3_pkg::op_br:
      begin
        seq.inst_class = lc3_pkg::control;
        br_taken       = |(cc & inst[11:9]); // Any requested flag set
      end
      lc3_pkg::op_jmp:
      begin
        seq.inst_class = lc3_pkg::control;
        exec.off_sel   = lc3_pkg::off_zero;
        exec.base_sel  = lc3_pkg::base_src1;
        br_taken       = 1'b1;
      end
      lc3_pkg::op_jsr:
      begin
        seq.inst_class = lc3_pkg::control;
        seq.store_pc   = 1'b1; // Both JSR and JSRR link
        exec.wb_sel    = lc3_pkg::wb_npc;
        br_taken       = 1'b1;
        if (inst[11])
          exec.off_sel = lc3_pkg::off_11; // JSR, PC relative
        else
        begin
          exec.off_sel  = lc3_pkg::off_zero; // JSRR, register target
          exec.base_sel = lc3_pkg::base_src1;
        end
      end
      lc3_pkg::op_ld, lc3_pkg::op_ldr, lc3_pkg::op_lea:
      begin
        seq.inst_class = lc3_pkg::load;
        exec.wb_sel    = lc3_pkg::wb_mem;
        if (opcode == lc3_pkg::op_ldr)
        begin
          exec.off_sel  = lc3_pkg::off_6;
          exec.base_sel = lc3_pkg::base_src1;
        end
        if (opcode == lc3_pkg::op_lea)
        begin
          seq.addr_only = 1'b1;
          exec.wb_sel   = lc3_pkg::wb_addr; // Address itself is the result
        end
      end
      lc3_pkg::op_st, lc3_pkg::op_str:
      begin
        seq.inst_class = lc3_pkg::store;
        if (opcode == lc3_pkg::op_str)
        begin
          exec.off_sel  = lc3_pkg::off_6;
          exec.base_sel = lc3_pkg::base_src1;
        end
      end
      default: seq.inst_class = lc3_pkg::illegal;
    endcase
  end

endmodule

// File: decode/regfile.sv
// General register file
`timescale 1ns/1ps

module regfile (
  input  logic               clock,
  input  logic               write,
  input  lc3_pkg::reg_addr_t write_reg_num,
  input  lc3_pkg::word_t     write_data,
  input  lc3_pkg::reg_addr_t read_num1,
  input  lc3_pkg::reg_addr_t read_num2,
  output lc3_pkg::word_t     read_data1,
  output lc3_pkg::word_t     read_data2
);

  lc3_pkg::word_t regs [lc3_pkg::reg_count];

  // Asynchronous reads
  assign read_data1 = regs[read_num1];
  assign read_data2 = regs[read_num2];

  always_ff @(posedge clock)
  begin
    if (write)
      regs[write_reg_num] <= write_data;
  end

endmodule

// File: common/lc3_pkg.sv
// LC-3 core shared definitions
package lc3_pkg;

  localparam int word_w = 16; // Data and address width
  localparam int reg_count = 8; // General registers R0..R7
  localparam logic [word_w-1:0] reset_pc = 16'h3000; // First fetch address

  typedef logic [word_w-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

  // Opcodes from ir[15:12]
  typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ld   = 4'b0010,
    op_st   = 4'b0011,
    op_jsr  = 4'b0100, // JSR and JSRR, split by ir[11]
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100, // JMP and RET
    op_res  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
  } opcode_t;

  // Instruction phases
  typedef enum logic [3:0] {
    update_pc,
    fetch,
    decode,
    execute,
    write_reg,
    branch,
    address,
    read_mem,
    write_mem,
    halt
  } state_t;

  typedef enum logic [2:0] {alu, control, load, store, illegal} inst_class_t;

  typedef enum logic [1:0] {alu_add, alu_and, alu_not} alu_op_t;
  typedef enum logic [1:0] {off_11, off_9, off_6, off_zero} off_sel_t;
  typedef enum logic {base_npc, base_src1} base_sel_t;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_addr, wb_npc} wb_sel_t;

  typedef struct packed {
    inst_class_t inst_class;
    logic        store_pc;  // JSR/JSRR write R7
    logic        addr_only; // LEA skips memory
  } seq_ctrl_t;

  typedef struct packed {
    alu_op_t   alu_op;
    off_sel_t  off_sel;
    base_sel_t base_sel;
    logic      use_imm;  // imm5 as second ALU operand
    wb_sel_t   wb_sel;
  } exec_ctrl_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } mem_bus_t;

endpackage
